/* src/lpPkg.sv */
// Widths, typedefs, ASCII codes, operation and state enums, line and serial constants
package lpPkg;

   //////////////////////////////////////////////////
   // Data widths
   //////////////////////////////////////////////////

   typedef logic [7:0]  charT;
   typedef logic [11:0] ramWordT;
   typedef logic [7:0]  ramAddrT;
   typedef logic [7:0]  columnT;

   // Operation picked from RAM control field and delimiter hold
   typedef enum logic [1:0] {printCbuf, printRamd, printDvfu, raiseIntr} printOpT;

   // Character processor states
   typedef enum logic [2:0] {
      stateIdle, stateParse, stateWrapLf, stateTab,
      stateWrapCh, stateDvfu, stateWait, stateDelay
   } printStateT;

   //////////////////////////////////////////////////
   // Line format and serial timing
   //////////////////////////////////////////////////

   localparam columnT lineWidth = 8'd132;
   localparam int tabStop = 8;
   localparam int tabCntW = $clog2(tabStop);

   // Short bit period keeps simulation quick
   localparam int clocksPerBit = 4;
   localparam int baudCntW = $clog2(clocksPerBit);

   // ASCII codes
   localparam charT asciiNul  = 8'h00;
   localparam charT asciiTab  = 8'h09;
   localparam charT asciiLf   = 8'h0a;
   localparam charT asciiVt   = 8'h0b;
   localparam charT asciiFf   = 8'h0c;
   localparam charT asciiCr   = 8'h0d;
   localparam charT asciiSp   = 8'h20;
   localparam charT asciiXon  = 8'h11;
   localparam charT asciiXoff = 8'h13;

   // Bit 7 marks a DVFU command, in place of the paper instruction line
   localparam charT dvfuFlag = 8'h80;

endpackage

/* src/lpCharIntake.sv */
// Character buffer, translation RAM with host write port, character loaded strobe
`timescale 1ns/1ps

module lpCharIntake (
   input  logic           clk,
   input  logic           rst,
   input  logic           charValid,
   input  lpPkg::charT    charByte,
   input  logic           ramWr,
   input  lpPkg::ramAddrT ramAddr,
   input  lpPkg::ramWordT ramData,
   output lpPkg::charT    cbuf,
   output lpPkg::ramWordT ramd,
   output logic           charLoaded
);
   import lpPkg::*;

   // Translation RAM, one word per character code
   ramWordT ram [0:255];

   // Host load port
   always_ff @(posedge clk)
   begin
      if (ramWr)
      begin
         ram[ramAddr] <= ramData;
      end
   end

   // Buffer and RAM word captured on the same edge
   // Read addressed by the incoming char, so one cycle of delay
   always_ff @(posedge clk)
   begin
      if (charValid)
      begin
         cbuf <= charByte;
         ramd <= ram[charByte];
      end
   end

   // Both cbuf and ramd valid one cycle after charValid
   always_ff @(posedge clk)
   begin
      if (rst)
         charLoaded <= 1'b0;
      else
         charLoaded <= charValid;
   end

endmodule

/* src/lpPrintData.sv */
// Character processor FSM with operation lookup, line wrap, tab expansion and DVFU output
`timescale 1ns/1ps

module lpPrintData (
   input  logic           clk,
   input  logic           rst,
   input  logic           charLoaded,
   input  lpPkg::charT    cbuf,
   input  lpPkg::ramWordT ramd,
   input  lpPkg::columnT  column,
   input  logic           modePrint,
   input  logic           modeTest,
   input  logic           modeLoadVfu,
   input  logic           delimHold,
   input  logic           demand,
   output logic           printStrobe,
   output lpPkg::charT    printByte,
   output logic           clearColumn,
   output logic           incColumn,
   output logic           setUndef,
   output logic           ready
);
   import lpPkg::*;

   printStateT         state;
   printOpT            op;
   charT               pdat;
   logic [tabCntW-1:0] tabCount;
   logic [3:0]         ctrl;
   logic               linkFree;

   // Control field sits above the translated char
   assign ctrl = ramd[11:8];

   // Demand only drops the cycle after a strobe
   assign linkFree = demand && !printStrobe;

   //////////////////////////////////////////////////
   // Operation lookup, LP20 table
   //////////////////////////////////////////////////

   always_comb
   begin
      case (ctrl)
         4'd0:                op = delimHold ? printRamd : printCbuf;
         4'd1:                op = delimHold ? printDvfu : printCbuf;
         4'd2, 4'd4, 4'd6:    op = printRamd;
         4'd3, 4'd5, 4'd7:    op = printDvfu;
         4'd10:               op = delimHold ? raiseIntr : printRamd;
         4'd11:               op = delimHold ? raiseIntr : printDvfu;
         // 8, 9 and 12 to 15 undefined
         default:             op = raiseIntr;
      endcase
   end

   //////////////////////////////////////////////////
   // Processor FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= stateIdle;
         printStrobe <= 1'b0;
         printByte   <= '0;
         clearColumn <= 1'b0;
         incColumn   <= 1'b0;
         setUndef    <= 1'b0;
         tabCount    <= '0;
         pdat        <= '0;
      end
      else
      begin
         // Pulses last one cycle
         printStrobe <= 1'b0;
         clearColumn <= 1'b0;
         incColumn   <= 1'b0;
         setUndef    <= 1'b0;

         case (state)
            // Wait for a loaded character
            stateIdle:
               if (charLoaded)
               begin
                  // Load DVFU mode sends cbuf as is
                  if (modeLoadVfu)
                  begin
                     pdat  <= cbuf;
                     state <= stateDvfu;
                  end
                  else if (modePrint || modeTest)
                  begin
                     case (op)
                        printCbuf:
                        begin
                           pdat  <= cbuf;
                           state <= stateParse;
                        end
                        printRamd:
                        begin
                           pdat  <= ramd[7:0];
                           state <= stateParse;
                        end
                        printDvfu:
                        begin
                           pdat  <= ramd[7:0];
                           state <= stateDvfu;
                        end
                        default:
                        begin
                           // Undefined char, nothing printed
                           setUndef <= 1'b1;
                           state    <= stateWait;
                        end
                     endcase
                  end
               end

            // Classify the char
            stateParse:
               case (pdat)
                  // NUL is dropped
                  asciiNul:
                     state <= stateWait;
                  // Line terminators go out and restart the column
                  asciiCr, asciiLf, asciiVt, asciiFf:
                     if (linkFree)
                     begin
                        printByte   <= pdat;
                        printStrobe <= 1'b1;
                        clearColumn <= 1'b1;
                        tabCount    <= '0;
                        state       <= stateWait;
                     end
                  // First space of a tab
                  asciiTab:
                     if (linkFree)
                     begin
                        printByte   <= asciiSp;
                        printStrobe <= 1'b1;
                        incColumn   <= 1'b1;
                        tabCount    <= tabCount + 1'b1;
                        state       <= stateTab;
                     end
                  // Printable, counted for wrap
                  default:
                     if (linkFree)
                     begin
                        if (column >= lineWidth)
                        begin
                           // Full line, CR first
                           printByte   <= asciiCr;
                           printStrobe <= 1'b1;
                           clearColumn <= 1'b1;
                           tabCount    <= '0;
                           state       <= stateWrapLf;
                        end
                        else
                        begin
                           printByte   <= pdat;
                           printStrobe <= 1'b1;
                           incColumn   <= 1'b1;
                           tabCount    <= tabCount + 1'b1;
                           state       <= stateWait;
                        end
                     end
               endcase

            // LF half of the wrap
            stateWrapLf:
               if (linkFree)
               begin
                  printByte   <= asciiLf;
                  printStrobe <= 1'b1;
                  clearColumn <= 1'b1;
                  tabCount    <= '0;
                  state       <= stateWrapCh;
               end

            // The char that caused the wrap
            stateWrapCh:
               if (linkFree)
               begin
                  printByte   <= pdat;
                  printStrobe <= 1'b1;
                  incColumn   <= 1'b1;
                  tabCount    <= tabCount + 1'b1;
                  state       <= stateWait;
               end

            // More spaces until the counter wraps to a tab stop
            stateTab:
               if (tabCount == '0)
                  state <= stateWait;
               else if (linkFree)
               begin
                  printByte   <= asciiSp;
                  printStrobe <= 1'b1;
                  incColumn   <= 1'b1;
                  tabCount    <= tabCount + 1'b1;
               end

            // Vertical format command, flagged in bit 7
            stateDvfu:
               if (linkFree)
               begin
                  printByte   <= dvfuFlag | {1'b0, pdat[6:0]};
                  printStrobe <= 1'b1;
                  clearColumn <= 1'b1;
                  tabCount    <= '0;
                  state       <= stateWait;
               end

            // Transmitter finishes the frame
            stateWait:
               if (linkFree)
                  state <= stateDelay;

            stateDelay:
               state <= stateIdle;

            default:
               state <= stateIdle;
         endcase
      end
   end

   // Next char accepted only when idle and link free
   assign ready = (state == stateIdle) && demand;

endmodule

/* src/lpColumnStatus.sv */
// Column counter, sticky undefined character flag, printer data valid toggle
`timescale 1ns/1ps

module lpColumnStatus (
   input  logic          clk,
   input  logic          rst,
   input  logic          init,
   input  logic          clearColumn,
   input  logic          incColumn,
   input  logic          setUndef,
   input  logic          printStrobe,
   output lpPkg::columnT column,
   output logic          undefChar,
   output logic          dataValid
);

   // Column count, clear wins over increment
   always_ff @(posedge clk)
   begin
      if (rst || clearColumn)
         column <= '0;
      else if (incColumn)
         column <= column + 1'b1;
   end

   // Sticky until init
   always_ff @(posedge clk)
   begin
      if (rst || init)
         undefChar <= 1'b0;
      else if (setUndef)
         undefChar <= 1'b1;
   end

   // Flips once per printer strobe
   always_ff @(posedge clk)
   begin
      if (rst || init)
         dataValid <= 1'b0;
      else if (printStrobe)
         dataValid <= ~dataValid;
   end

endmodule

/* src/lpUartTx.sv */
// 8N1 transmitter, takes a printer strobe and reports demand
`timescale 1ns/1ps

module lpUartTx (
   input  logic        clk,
   input  logic        rst,
   input  logic        printStrobe,
   input  lpPkg::charT printByte,
   input  logic        xoffHeld,
   output logic        txd,
   output logic        demand
);
   import lpPkg::*;

   logic                busy;
   logic [baudCntW-1:0] clkCount;
   logic [3:0]          bitCount;
   // Stop, data LSB first, start
   logic [9:0]          shiftReg;

   //////////////////////////////////////////////////
   // Frame shifter
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         clkCount <= '0;
         bitCount <= '0;
         shiftReg <= '1;
      end
      else if (!busy)
      begin
         if (printStrobe)
         begin
            busy     <= 1'b1;
            clkCount <= '0;
            bitCount <= '0;
            shiftReg <= {1'b1, printByte, 1'b0};
         end
      end
      else if (clkCount == baudCntW'(clocksPerBit - 1))
      begin
         // End of bit period
         clkCount <= '0;
         shiftReg <= {1'b1, shiftReg[9:1]};
         bitCount <= bitCount + 1'b1;
         if (bitCount == 4'd9)
            busy <= 1'b0;
      end
      else
         clkCount <= clkCount + 1'b1;
   end

   // Line sits at the stop level when idle
   assign txd = shiftReg[0];

   // Idle and printer not holding off
   assign demand = !busy && !xoffHeld;

endmodule

/* src/lpXonRx.sv */
// 8N1 receiver decoding only XON and XOFF into a hold level
`timescale 1ns/1ps

module lpXonRx (
   input  logic clk,
   input  logic rst,
   input  logic rxd,
   output logic xoffHeld
);
   import lpPkg::*;

   logic [1:0]          rxSync;
   logic                busy;
   logic [baudCntW-1:0] clkCount;
   logic [3:0]          bitIndex;
   charT                shiftReg;
   logic                midBit;

   // Two flop synchronizer, idles high
   always_ff @(posedge clk)
   begin
      if (rst)
         rxSync <= 2'b11;
      else
         rxSync <= {rxSync[0], rxd};
   end

   // Sample point near the middle of each bit
   assign midBit = busy && (clkCount == baudCntW'(clocksPerBit / 2 - 1));

   //////////////////////////////////////////////////
   // Bit timing and decode
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         clkCount <= '0;
         bitIndex <= '0;
         xoffHeld <= 1'b0;
      end
      else if (!busy)
      begin
         // Start bit edge
         if (!rxSync[1])
         begin
            busy     <= 1'b1;
            clkCount <= '0;
            bitIndex <= '0;
         end
      end
      else
      begin
         if (clkCount == baudCntW'(clocksPerBit - 1))
         begin
            clkCount <= '0;
            bitIndex <= bitIndex + 1'b1;
         end
         else
            clkCount <= clkCount + 1'b1;

         if (midBit)
         begin
            // Glitch, not a real start bit
            if (bitIndex == 4'd0 && rxSync[1])
               busy <= 1'b0;
            // Stop bit, act on flow control bytes only
            else if (bitIndex == 4'd9)
            begin
               busy <= 1'b0;
               if (rxSync[1] && shiftReg == asciiXoff)
                  xoffHeld <= 1'b1;
               else if (rxSync[1] && shiftReg == asciiXon)
                  xoffHeld <= 1'b0;
            end
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk)
   begin
      if (midBit && bitIndex != 4'd0 && bitIndex != 4'd9)
         shiftReg <= {rxSync[1], shiftReg[7:1]};
   end

endmodule

/* src/lpTop.sv */
// Printer data path top, intake, processor, status and serial link
`timescale 1ns/1ps

module lpTop (
   input  logic           clk,
   input  logic           rst,
   input  logic           charValid,
   input  lpPkg::charT    charByte,
   input  logic           ramWr,
   input  lpPkg::ramAddrT ramAddr,
   input  lpPkg::ramWordT ramData,
   input  logic           init,
   input  logic           modePrint,
   input  logic           modeTest,
   input  logic           modeLoadVfu,
   input  logic           delimHold,
   output logic           txd,
   input  logic           rxd,
   output logic           ready,
   output lpPkg::columnT  column,
   output logic           undefChar,
   output logic           dataValid
);
   import lpPkg::*;

   charT    cbuf;
   ramWordT ramd;
   charT    printByte;
   logic    charLoaded;
   logic    printStrobe;
   logic    clearColumn;
   logic    incColumn;
   logic    setUndef;
   logic    demand;
   logic    xoffHeld;

   // Host side capture
   lpCharIntake u_intake (
      .clk(clk), .rst(rst),
      .charValid(charValid), .charByte(charByte),
      .ramWr(ramWr), .ramAddr(ramAddr), .ramData(ramData),
      .cbuf(cbuf), .ramd(ramd), .charLoaded(charLoaded)
   );

   // Character processing
   lpPrintData u_printData (
      .clk(clk), .rst(rst),
      .charLoaded(charLoaded), .cbuf(cbuf), .ramd(ramd), .column(column),
      .modePrint(modePrint), .modeTest(modeTest), .modeLoadVfu(modeLoadVfu),
      .delimHold(delimHold), .demand(demand),
      .printStrobe(printStrobe), .printByte(printByte),
      .clearColumn(clearColumn), .incColumn(incColumn), .setUndef(setUndef),
      .ready(ready)
   );

   lpColumnStatus u_status (
      .clk(clk), .rst(rst), .init(init),
      .clearColumn(clearColumn), .incColumn(incColumn), .setUndef(setUndef),
      .printStrobe(printStrobe),
      .column(column), .undefChar(undefChar), .dataValid(dataValid)
   );

   // Serial link to the printer
   lpUartTx u_uartTx (
      .clk(clk), .rst(rst),
      .printStrobe(printStrobe), .printByte(printByte), .xoffHeld(xoffHeld),
      .txd(txd), .demand(demand)
   );

   lpXonRx u_xonRx (
      .clk(clk), .rst(rst), .rxd(rxd), .xoffHeld(xoffHeld)
   );

endmodule

/* verification/lpTop_assert.sv */
// Concurrent checks on printer strobe, transmitter demand and character load, bound into lpTop
`timescale 1ns/1ps

module lpTopAssert (
   input logic                clk,
   input logic                rst,
   input logic                printStrobe,
   input logic                demand,
   input logic                charLoaded,
   input lpPkg::printStateT   state
);
   import lpPkg::*;

   // Strobe only into a free link
   strobeWithDemand: assert property (@(posedge clk) disable iff (rst)
      printStrobe |-> demand)
      else $error("printStrobe high while demand low");

   // Transmitter takes the byte, demand stays down for a whole frame
   demandLowForFrame: assert property (@(posedge clk) disable iff (rst)
      printStrobe |=> !demand [*(10 * clocksPerBit)])
      else $error("demand rose before a full frame after printStrobe");

   // A loaded character always finds the processor idle
   loadOnlyIdle: assert property (@(posedge clk) disable iff (rst)
      charLoaded |-> (state == stateIdle))
      else $error("character loaded while the processor was not idle");

endmodule

bind lpTop lpTopAssert u_assert (
   .clk(clk),
   .rst(rst),
   .printStrobe(printStrobe),
   .demand(demand),
   .charLoaded(charLoaded),
   .state(u_printData.state)
);

/* verification/lpTb.sv */
// Testbench for the printer data path, file driven stimulus, txd decoder, compare tasks
`timescale 1ns/1ps

module lpTb;
   import lpPkg::*;

   localparam int clkPeriod  = 20;
   localparam int bitTime    = clkPeriod * clocksPerBit;
   localparam int frameTime  = 10 * bitTime;
   localparam int maxRecords = 256;
   // Longest wait is a full tab of eight frames plus margin
   localparam int readyLimit = 12 * 10 * clocksPerBit;

   logic    clk;
   logic    rst;
   logic    charValid;
   charT    charByte;
   logic    ramWr;
   ramAddrT ramAddr;
   ramWordT ramData;
   logic    init;
   logic    modePrint;
   logic    modeTest;
   logic    modeLoadVfu;
   logic    delimHold;
   logic    txd;
   logic    rxd;
   logic    ready;
   columnT  column;
   logic    undefChar;
   logic    dataValid;

   // Bytes seen on txd, oldest first
   charT        rxQueue [$];
   // Frames decoded since reset or init
   int          txCount;
   logic [63:0] recCode [maxRecords];
   int          recA [maxRecords];
   int          recB [maxRecords];
   int          recCount;

   lpTop u_dut (
      .clk(clk), .rst(rst),
      .charValid(charValid), .charByte(charByte),
      .ramWr(ramWr), .ramAddr(ramAddr), .ramData(ramData),
      .init(init), .modePrint(modePrint), .modeTest(modeTest),
      .modeLoadVfu(modeLoadVfu), .delimHold(delimHold),
      .txd(txd), .rxd(rxd), .ready(ready),
      .column(column), .undefChar(undefChar), .dataValid(dataValid)
   );

   always #(clkPeriod / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // Failure and compare tasks
   //////////////////////////////////////////////////

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkChar(input string name, input charT got, input charT exp);
      if (got !== exp)
         stopRun($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic checkColumn(input string name, input columnT got, input columnT exp);
      if (got !== exp)
         stopRun($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic checkFlag(input string name, input bit got, input bit exp);
      if (got !== exp)
         stopRun($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   //////////////////////////////////////////////////
   // Host and line drivers
   //////////////////////////////////////////////////

   // Inputs change 2 ns after the rising edge
   task automatic stepClock;
      @(posedge clk);
      #2;
   endtask

   task automatic waitReady;
      int cycles;
      cycles = 0;
      while (ready !== 1'b1)
      begin
         if (cycles == readyLimit)
            stopRun("timed out waiting for ready to rise");
         else
         begin
            stepClock();
            cycles++;
         end
      end
   endtask

   // One host character, returns once the processor is idle again
   task automatic sendChar(input charT value);
      waitReady();
      charValid = 1'b1;
      charByte  = value;
      stepClock();
      charValid = 1'b0;
      // Processor has left idle by now
      stepClock();
      waitReady();
      // Toggle per strobe, one strobe per frame
      checkFlag("dataValid", dataValid, txCount[0]);
   endtask

   // 8N1 frame on rxd, then idle so the stop bit is taken
   task automatic sendSerial(input charT value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         rxd = frame[i];
         repeat (clocksPerBit) stepClock();
      end
      repeat (2 * clocksPerBit) stepClock();
   endtask

   // Every word ctrl 0, low byte from the whole address
   task automatic loadDefaultRam;
      for (int addr = 0; addr < 256; addr++)
      begin
         ramWr   = 1'b1;
         ramAddr = ramAddrT'(addr);
         ramData = {4'h0, ramAddrT'(addr) ^ 8'h5a};
         stepClock();
      end
      ramWr = 1'b0;
   endtask

   task automatic expectBytes(input charT value, input int count);
      charT got;
      for (int i = 0; i < count; i++)
      begin
         if (rxQueue.size() == 0)
            stopRun($sformatf("byte 0x%h expected on txd but nothing was received", value));
         else
         begin
            got = rxQueue.pop_front();
            checkChar("txd byte", got, value);
         end
      end
   endtask

   // Link held off, no host handshake and no start bit
   task automatic holdQuiet(input int cycles);
      for (int i = 0; i < cycles; i++)
      begin
         if (ready !== 1'b0)
            stopRun("ready went high while XOFF was in force");
         else if (txd !== 1'b1)
            stopRun("txd left idle while XOFF was in force");
         stepClock();
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus file
   //////////////////////////////////////////////////

   task automatic readRecords;
      int                 fd;
      int                 code;
      int                 a;
      int                 b;
      logic [63:0]        word;
      logic [8*200-1:0]   rest;
      recCount = 0;
      fd = $fopen("verification/lpTb_input.txt", "r");
      if (fd == 0)
         stopRun("cannot open the stimulus file");
      else
      begin
         while (!$feof(fd))
         begin
            word = '0;
            code = $fscanf(fd, "%s", word);
            if (code == 1 && word == "#")
               code = $fgets(rest, fd);
            else if (code == 1)
            begin
               code = $fscanf(fd, "%h %h", a, b);
               if (code != 2 || recCount == maxRecords)
                  stopRun("malformed or oversized stimulus file");
               else
               begin
                  recCode[recCount] = word;
                  recA[recCount]    = a;
                  recB[recCount]    = b;
                  recCount++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic runRecord(input logic [63:0] code, input int a, input int b);
      case (code)
         "R":
         begin
            ramWr   = 1'b1;
            ramAddr = ramAddrT'(a);
            ramData = ramWordT'(b);
            stepClock();
            ramWr   = 1'b0;
         end
         "M":
         begin
            modePrint   = a[0];
            modeTest    = a[1];
            modeLoadVfu = a[2];
            delimHold   = a[3];
            stepClock();
         end
         "C": sendChar(charT'(a));
         "F":
            for (int i = 0; i < a; i++)
               sendChar(charT'(b));
         "S": sendSerial(charT'(a));
         "E": expectBytes(charT'(a), b);
         "K": checkColumn("column", column, columnT'(a));
         "U": checkFlag("undefChar", undefChar, a[0]);
         "I":
         begin
            init    = 1'b1;
            txCount = 0;
            stepClock();
            init    = 1'b0;
         end
         "H": holdQuiet(a);
         "Z":
            if (rxQueue.size() != 0)
               stopRun($sformatf("unexpected byte 0x%h on txd", rxQueue[0]));
         default: stopRun("unknown record code in the stimulus file");
      endcase
   endtask

   //////////////////////////////////////////////////
   // Processes
   //////////////////////////////////////////////////

   // Samples clear of clock edges, since txd moves on posedge
   initial
   begin : serialDecode
      charT rxByte;
      forever
      begin
         @(negedge txd);
         #(bitTime / 2 - clkPeriod / 2);
         if (txd !== 1'b0)
            stopRun("start bit on txd shorter than half a bit");
         else
         begin
            for (int i = 0; i < 8; i++)
            begin
               #(bitTime);
               rxByte[i] = txd;
            end
            #(bitTime);
            if (txd !== 1'b1)
               stopRun("missing stop bit on txd");
            else
            begin
               rxQueue.push_back(rxByte);
               txCount++;
            end
         end
      end
   end

   // Bound from the number of records read
   initial
   begin : watchdog
      #1;
      #(recCount * 40 * frameTime);
      stopRun("watchdog expired before the stimulus finished");
   end

   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      charValid   = 1'b0;
      charByte    = '0;
      ramWr       = 1'b0;
      ramAddr     = '0;
      ramData     = '0;
      init        = 1'b0;
      modePrint   = 1'b0;
      modeTest    = 1'b0;
      modeLoadVfu = 1'b0;
      delimHold   = 1'b0;
      rxd         = 1'b1;
      txCount     = 0;
      readRecords();
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      loadDefaultRam();
      for (int r = 0; r < recCount; r++)
         runRecord(recCode[r], recA[r], recB[r]);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* all.f */
src/lpPkg.sv
src/lpCharIntake.sv
src/lpPrintData.sv
src/lpColumnStatus.sv
src/lpUartTx.sv
src/lpXonRx.sv
src/lpTop.sv
verification/lpTop_assert.sv
verification/lpTb.sv

/* verification/lpTb_input.txt */
# code a b in hex: R addr word, M modes (bit0 print, bit1 test, bit2 loadVfu, bit3 delim), C char
# F count char, S rxd byte, E byte count, K column, U undefChar, I init, H quiet cycles, Z queue empty
R 61 241
R 76 305
R 7e 800
M 1 0
C 48 0
C 61 0
C 00 0
E 48 1
E 41 1
K 2 0
C 0d 0
C 0a 0
C 0c 0
C 0b 0
E 0d 1
E 0a 1
E 0c 1
E 0b 1
K 0 0
F 7 2e
C 09 0
E 2e 7
E 20 1
K 8 0
C 76 0
E 85 1
M 5 0
C 47 0
E c7 1
M 1 0
C 7e 0
Z 0 0
U 1 0
I 0 0
U 0 0
S 13 0
H 100 0
S 11 0
C 42 0
C 43 0
E 42 1
E 43 1
K 2 0
C 09 0
E 20 6
K 8 0
C 0d 0
E 0d 1
F 84 58
E 58 84
K 84 0
C 59 0
E 0d 1
E 0a 1
E 59 1
K 1 0
Z 0 0
